//--- tb.f
+incdir+tests
hw/hazard_pkg.sv
hw/int_forward.sv
hw/fpu_forward.sv
hw/load_use_detect.sv
hw/fpu_issue_ctrl.sv
hw/stall_flush_ctrl.sv
hw/hazard_unit.sv
tests/tb_hazard_unit.sv

//--- tests/tb_hazard_ref.svh
`ifndef TB_HAZARD_REF_SVH
`define TB_HAZARD_REF_SVH

// integer select for one operand, memory stage beats write-back
function automatic logic [2:0] int_sel_for(input logic [4:0] rs, input logic is_int,
                                           input stage_m_t m, input stage_w_t w);
    logic [2:0] sel;
    sel = FWD_NONE;
    if (is_int && rs != 5'd0 && m.reg_write && m.rd == rs) begin
        case (m.result_src)
            RES_PC4:     sel = FWD_PC4_M;
            RES_IMM:     sel = FWD_IMM_M;
            RES_FPU_RD1: sel = FWD_FPU_RD1_M;
            RES_FPU:     sel = FWD_FPU_RES_M;
            default:     sel = FWD_ALU_M; // alu, plus load/in/fmv fallback
        endcase
    end else if (is_int && rs != 5'd0 && w.reg_write && w.rd == rs) begin
        sel = FWD_WB;
    end
    return sel;
endfunction

// f0 is a normal register here
function automatic logic [1:0] fp_sel_for(input logic [4:0] rs, input logic is_fp,
                                          input stage_m_t m, input stage_w_t w);
    logic [1:0] sel;
    sel = FFWD_NONE;
    if (is_fp && m.fpu_reg_write && m.rd == rs) begin
        if (m.result_src == RES_INT_TO_FPU) begin
            sel = FFWD_RD1_M;
        end else if (m.result_src == RES_FPU) begin
            sel = FFWD_FPU_RES_M;
        end
    end else if (is_fp && w.fpu_reg_write && w.rd == rs) begin
        sel = FFWD_WB;
    end
    return sel;
endfunction

function automatic fwd_sel_t ref_fwd(input stage_e_t e, input stage_m_t m, input stage_w_t w);
    fwd_sel_t f;
    logic     fp1;
    fp1 = e.s_fpu && !e.mem_write; // fsw rs1 is an address
    f.rd1     = int_sel_for(e.rs1, !fp1, m, w);
    f.rd2     = int_sel_for(e.rs2, !e.s_fpu, m, w);
    f.fpu_rd1 = fp_sel_for(e.rs1, fp1, m, w);
    f.fpu_rd2 = fp_sel_for(e.rs2, e.s_fpu, m, w);
    f.fpu_rd3 = fp_sel_for(e.rs3, e.s_fpu, m, w);
    return f;
endfunction

function automatic logic ref_lw_stall(input stage_d_t d, input stage_e_t e);
    logic late;
    logic int_use;
    logic fp_use;
    late    = (e.result_src == RES_MEM) || (e.result_src == RES_IN);
    int_use = e.reg_write && e.rd != 5'd0
              && ((((!d.s_fpu) || d.mem_write) && d.rs1 == e.rd)
                  || (!d.s_fpu && d.rs2 == e.rd));
    fp_use  = e.fpu_reg_write
              && ((d.s_fpu && !d.mem_write && d.rs1 == e.rd)
                  || (d.s_fpu && (d.rs2 == e.rd || d.rs3 == e.rd)));
    return late && (int_use || fp_use);
endfunction

function automatic logic ref_cache_stall(input logic rd, input logic wr, input logic valid);
    return (rd || wr) && !valid;
endfunction

function automatic pipe_ctrl_t ref_ctrl(input logic cstall, input logic in_s, input logic out_s,
                                        input logic fpu_s, input logic lw, input logic pc);
    pipe_ctrl_t c;
    c = '0;
    if (cstall || in_s || out_s) begin
        c.stall_f = 1'b1;
        c.stall_d = 1'b1;
        c.stall_e = 1'b1;
        c.stall_m = 1'b1;
        c.stall_w = 1'b1;
    end else if (fpu_s) begin
        c.stall_f = 1'b1;
        c.stall_d = 1'b1;
        c.stall_e = 1'b1;
        c.flush_m = 1'b1;
    end else if (lw) begin
        c.stall_f = 1'b1;
        c.stall_d = 1'b1;
        c.flush_e = 1'b1;
    end else if (pc) begin
        c.flush_d = 1'b1;
        c.flush_e = 1'b1;
    end
    return c;
endfunction

`endif

//--- tests/tb_hazard_unit.sv
`timescale 1ns/1ps

module tb_hazard_unit import hazard_pkg::*; ();

    logic       clk = 1'b0;
    logic       rst_n;
    stage_d_t   stg_d;
    stage_e_t   stg_e;
    stage_m_t   stg_m;
    stage_w_t   stg_w;
    logic       cache_data_valid;
    logic       in_stall;
    logic       out_stall;
    logic       fast_fpu_valid;
    logic       slow_fpu_valid;
    pipe_ctrl_t ctrl;
    fwd_sel_t   fwd;
    logic       cache_stall;
    logic       lw_stall;
    logic       fast_fpu_en_pulse;
    logic       slow_fpu_en_pulse;

    int         errors;
    int         checks;
    int         start;
    logic       cmp_en; // compare process runs while the fpu fsm idles
    fwd_sel_t   exp_fwd;
    logic       exp_lw;
    logic       exp_cs;
    pipe_ctrl_t exp_ctrl;

    `include "tb_hazard_ref.svh"

    hazard_unit DUT (.*);

    always #20 clk = ~clk;

    function automatic logic [4:0] rand_reg();
        return 5'($urandom_range(0, 3)); // few regs so hits are common
    endfunction

    function automatic logic rand_bit();
        return 1'($urandom_range(0, 1));
    endfunction

    always @(negedge clk) begin
        if (cmp_en) begin
            exp_fwd  = ref_fwd(stg_e, stg_m, stg_w);
            exp_lw   = ref_lw_stall(stg_d, stg_e);
            exp_cs   = ref_cache_stall(stg_m.mem_read, stg_m.mem_write, cache_data_valid);
            exp_ctrl = ref_ctrl(exp_cs, in_stall, out_stall, 1'b0, exp_lw, stg_e.pc_src);
            checks = checks + 1;
            if (fwd !== exp_fwd) begin
                errors = errors + 1;
                $display("FAILED fwd: expected %h, got %h", exp_fwd, fwd);
            end
            if (lw_stall !== exp_lw) begin
                errors = errors + 1;
                $display("FAILED lw_stall: expected %h, got %h", exp_lw, lw_stall);
            end
            if (cache_stall !== exp_cs) begin
                errors = errors + 1;
                $display("FAILED cache_stall: expected %h, got %h", exp_cs, cache_stall);
            end
            if (ctrl !== exp_ctrl) begin
                errors = errors + 1;
                $display("FAILED ctrl: expected %h, got %h", exp_ctrl, ctrl);
            end
            if (fast_fpu_en_pulse !== 1'b0 || slow_fpu_en_pulse !== 1'b0) begin
                errors = errors + 1;
                $display("FAILED fpu_en_pulse: expected %h, got %h", 2'b00,
                         {slow_fpu_en_pulse, fast_fpu_en_pulse});
            end
        end
    end

    task automatic quiet_inputs();
        stg_d            <= '0;
        stg_e            <= '0; // dispatch DU_INT
        stg_m            <= '0;
        stg_w            <= '0;
        cache_data_valid <= 1'b1;
        in_stall         <= 1'b0;
        out_stall        <= 1'b0;
        fast_fpu_valid   <= 1'b0;
        slow_fpu_valid   <= 1'b0;
    endtask

    task automatic randomize_stages();
        stage_d_t d;
        stage_e_t e;
        stage_m_t m;
        stage_w_t w;
        d.rs1 = rand_reg();
        d.rs2 = rand_reg();
        d.rs3 = rand_reg();
        d.s_fpu = rand_bit();
        d.mem_write = rand_bit();
        e.rs1 = rand_reg();
        e.rs2 = rand_reg();
        e.rs3 = rand_reg();
        e.rd = rand_reg();
        e.pc_src = rand_bit();
        e.result_src = 3'($urandom_range(0, 7));
        e.mem_write = rand_bit();
        e.s_fpu = rand_bit();
        e.reg_write = rand_bit();
        e.fpu_reg_write = rand_bit();
        e.dispatch = DU_INT;
        m.rd = rand_reg();
        m.result_src = 3'($urandom_range(0, 7));
        m.reg_write = rand_bit();
        m.fpu_reg_write = rand_bit();
        m.mem_read = rand_bit();
        m.mem_write = rand_bit();
        w.rd = rand_reg();
        w.reg_write = rand_bit();
        w.fpu_reg_write = rand_bit();
        stg_d <= d;
        stg_e <= e;
        stg_m <= m;
        stg_w <= w;
    endtask

    task automatic load_use_case(input string what, input stage_d_t d, input stage_e_t e,
                                 input logic exp_stall);
        pipe_ctrl_t exp;
        @(posedge clk);
        stg_d <= d;
        stg_e <= e;
        stg_m <= '0;
        stg_w <= '0;
        @(negedge clk);
        exp = '0;
        if (exp_stall) begin
            exp.stall_f = 1'b1;
            exp.stall_d = 1'b1;
            exp.flush_e = 1'b1;
        end
        checks = checks + 1;
        if (lw_stall !== exp_stall) begin
            errors = errors + 1;
            $display("FAILED lw_stall (%s): expected %h, got %h", what, exp_stall, lw_stall);
        end
        if (ctrl !== exp) begin
            errors = errors + 1;
            $display("FAILED ctrl (%s): expected %h, got %h", what, exp, ctrl);
        end
    endtask

    task automatic run_fpu(input logic slow);
        int         lat;
        int         cyc;
        string      unit;
        pipe_ctrl_t exp_fpu;
        lat  = $urandom_range(1, 8);
        cyc  = 0;
        unit = slow ? "slow" : "fast";
        @(posedge clk);
        stg_e.dispatch <= slow ? DU_SLOW_FPU : DU_FAST_FPU;
        @(negedge clk);
        exp_fpu = ref_ctrl(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        checks = checks + 1;
        if (fast_fpu_en_pulse !== !slow || slow_fpu_en_pulse !== slow) begin
            errors = errors + 1;
            $display("FAILED fpu_en_pulse (%s): expected %h, got %h", unit,
                     {slow, !slow}, {slow_fpu_en_pulse, fast_fpu_en_pulse});
        end
        if (ctrl !== exp_fpu) begin
            errors = errors + 1;
            $display("FAILED ctrl (%s issue): expected %h, got %h", unit, exp_fpu, ctrl);
        end
        // hold E until the unit answers
        while (ctrl.stall_e === 1'b1 && cyc < 20) begin
            @(posedge clk);
            cyc = cyc + 1;
            if (cyc == lat) begin
                if (slow) slow_fpu_valid <= 1'b1;
                else fast_fpu_valid <= 1'b1;
            end
            @(negedge clk);
            exp_fpu = ref_ctrl(1'b0, 1'b0, 1'b0, cyc < lat, 1'b0, 1'b0);
            checks = checks + 1;
            if (fast_fpu_en_pulse !== 1'b0 || slow_fpu_en_pulse !== 1'b0) begin
                errors = errors + 1;
                $display("FAILED fpu_en_pulse (%s wait): expected %h, got %h", unit,
                         2'b00, {slow_fpu_en_pulse, fast_fpu_en_pulse});
            end
            if (ctrl !== exp_fpu) begin
                errors = errors + 1;
                $display("FAILED ctrl (%s wait): expected %h, got %h", unit, exp_fpu, ctrl);
            end
        end
        if (ctrl.stall_e === 1'b1) begin
            $display("timeout: the %s FPU result never released stall_e", unit);
            $display("TEST FAIL");
            $finish;
        end
        if (cyc != lat) begin
            errors = errors + 1;
            $display("FAILED stall_e release cycle (%s): expected %h, got %h", unit, lat, cyc);
        end
        @(posedge clk);
        fast_fpu_valid <= 1'b0;
        slow_fpu_valid <= 1'b0;
        stg_e.dispatch <= DU_INT; // result instr leaves E
        @(posedge clk);
    endtask

    task automatic report_test(input string name, input int first);
        $display("test %s: %0d errors", name, errors - first);
    endtask

    initial begin
        void'($urandom(42863));
        errors = 0;
        checks = 0;
        cmp_en = 1'b0;
        rst_n <= 1'b0;
        quiet_inputs();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        start = errors;
        cmp_en = 1'b1;
        @(posedge clk);
        @(negedge clk);
        checks = checks + 1;
        if (ctrl !== '0 || cache_stall !== 1'b0 || lw_stall !== 1'b0
            || fast_fpu_en_pulse !== 1'b0 || slow_fpu_en_pulse !== 1'b0) begin
            errors = errors + 1;
            $display("FAILED reset outputs: expected %h, got %h", 12'h000,
                     {ctrl, cache_stall, lw_stall, fast_fpu_en_pulse, slow_fpu_en_pulse});
        end
        report_test("reset", start);

        start = errors;
        repeat (400) begin
            @(posedge clk);
            randomize_stages();
        end
        @(negedge clk);
        report_test("random forwarding", start);

        start = errors;
        load_use_case("lw then add rs1", stage_d_t'{rs1: 5'd5, default: '0},
            stage_e_t'{rd: 5'd5, reg_write: 1'b1, result_src: RES_MEM, default: '0}, 1'b1);
        load_use_case("in then sub rs2", stage_d_t'{rs2: 5'd9, default: '0},
            stage_e_t'{rd: 5'd9, reg_write: 1'b1, result_src: RES_IN, default: '0}, 1'b1);
        load_use_case("flw then fmadd rs3", stage_d_t'{rs3: 5'd7, s_fpu: 1'b1, default: '0},
            stage_e_t'{rd: 5'd7, fpu_reg_write: 1'b1, result_src: RES_MEM, default: '0}, 1'b1);
        load_use_case("lw then fsw address",
            stage_d_t'{rs1: 5'd6, s_fpu: 1'b1, mem_write: 1'b1, default: '0},
            stage_e_t'{rd: 5'd6, reg_write: 1'b1, result_src: RES_MEM, default: '0}, 1'b1);
        load_use_case("fmv.w.x then fadd", stage_d_t'{rs2: 5'd7, s_fpu: 1'b1, default: '0},
            stage_e_t'{rd: 5'd7, fpu_reg_write: 1'b1, result_src: RES_INT_TO_FPU,
                       default: '0}, 1'b0);
        @(posedge clk);
        quiet_inputs();
        report_test("load-use", start);

        start = errors;
        repeat (300) begin
            @(posedge clk);
            randomize_stages();
            cache_data_valid <= rand_bit();
            in_stall         <= ($urandom_range(0, 3) == 0);
            out_stall        <= ($urandom_range(0, 3) == 0);
        end
        @(negedge clk);
        report_test("priority", start);

        start = errors;
        cmp_en = 1'b0;
        @(posedge clk);
        quiet_inputs();
        run_fpu(1'b0);
        run_fpu(1'b1);
        report_test("fpu issue", start);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- hw/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import hazard_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  stage_d_t   stg_d,
    input  stage_e_t   stg_e,
    input  stage_m_t   stg_m,
    input  stage_w_t   stg_w,
    input  logic       cache_data_valid,
    input  logic       in_stall,
    input  logic       out_stall,
    input  logic       fast_fpu_valid,
    input  logic       slow_fpu_valid,
    output pipe_ctrl_t ctrl,
    output fwd_sel_t   fwd,
    output logic       cache_stall,
    output logic       lw_stall,
    output logic       fast_fpu_en_pulse,
    output logic       slow_fpu_en_pulse
);

    logic fpu_stall;

    int_forward u_int_forward (
        .stg_e   (stg_e),
        .stg_m   (stg_m),
        .stg_w   (stg_w),
        .rd1_sel (fwd.rd1),
        .rd2_sel (fwd.rd2)
    );

    fpu_forward u_fpu_forward (
        .stg_e    (stg_e),
        .stg_m    (stg_m),
        .stg_w    (stg_w),
        .frd1_sel (fwd.fpu_rd1),
        .frd2_sel (fwd.fpu_rd2),
        .frd3_sel (fwd.fpu_rd3)
    );

    load_use_detect u_load_use_detect (
        .stg_d    (stg_d),
        .stg_e    (stg_e),
        .lw_stall (lw_stall)
    );

    // stall_e and flush_e come back from the priority block
    fpu_issue_ctrl u_fpu_issue_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .dispatch          (stg_e.dispatch),
        .fast_fpu_valid    (fast_fpu_valid),
        .slow_fpu_valid    (slow_fpu_valid),
        .stall_e           (ctrl.stall_e),
        .flush_e           (ctrl.flush_e),
        .fast_fpu_en_pulse (fast_fpu_en_pulse),
        .slow_fpu_en_pulse (slow_fpu_en_pulse),
        .fpu_stall         (fpu_stall)
    );

    stall_flush_ctrl u_stall_flush_ctrl (
        .mem_read         (stg_m.mem_read),
        .mem_write        (stg_m.mem_write),
        .cache_data_valid (cache_data_valid),
        .in_stall         (in_stall),
        .out_stall        (out_stall),
        .fpu_stall        (fpu_stall),
        .lw_stall         (lw_stall),
        .pc_src           (stg_e.pc_src),
        .ctrl             (ctrl),
        .cache_stall      (cache_stall)
    );

endmodule

//--- hw/stall_flush_ctrl.sv
`timescale 1ns/1ps

module stall_flush_ctrl import hazard_pkg::*; (
    input  logic       mem_read,
    input  logic       mem_write,
    input  logic       cache_data_valid,
    input  logic       in_stall,
    input  logic       out_stall,
    input  logic       fpu_stall,
    input  logic       lw_stall,
    input  logic       pc_src,
    output pipe_ctrl_t ctrl,
    output logic       cache_stall
);

    logic global_stall;

    assign cache_stall  = (mem_read || mem_write) && !cache_data_valid; // miss in M
    assign global_stall = cache_stall || in_stall || out_stall;

    always_comb begin
        ctrl = '0;
        if (global_stall) begin
            // freeze everything
            ctrl.stall_f = 1'b1;
            ctrl.stall_d = 1'b1;
            ctrl.stall_e = 1'b1;
            ctrl.stall_m = 1'b1;
            ctrl.stall_w = 1'b1;
        end else if (fpu_stall) begin
            ctrl.stall_f = 1'b1;
            ctrl.stall_d = 1'b1;
            ctrl.stall_e = 1'b1;
            ctrl.flush_m = 1'b1; // bubble behind the fpu op
        end else if (lw_stall) begin
            ctrl.stall_f = 1'b1;
            ctrl.stall_d = 1'b1;
            ctrl.flush_e = 1'b1;
        end else if (pc_src) begin
            ctrl.flush_d = 1'b1; // taken branch, drop wrong path
            ctrl.flush_e = 1'b1;
        end
    end

    always_comb begin
        assert final (!(ctrl.stall_d && ctrl.flush_d)
                      && !(ctrl.stall_e && ctrl.flush_e)
                      && !(ctrl.stall_m && ctrl.flush_m))
            else $error("stall_flush_ctrl: stage stalled and flushed at once");
    end

endmodule

//--- hw/fpu_issue_ctrl.sv
`timescale 1ns/1ps

module fpu_issue_ctrl import hazard_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] dispatch,
    input  logic       fast_fpu_valid,
    input  logic       slow_fpu_valid,
    input  logic       stall_e,
    input  logic       flush_e,
    output logic       fast_fpu_en_pulse,
    output logic       slow_fpu_en_pulse,
    output logic       fpu_stall
);

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic       slow_sel; // unit in flight, 1 = slow
    logic       slow_sel_nxt;
    logic       unit_valid;

    assign unit_valid = slow_sel ? slow_fpu_valid : fast_fpu_valid;

    // outputs only look at state, dispatch and valid, never at stall_e
    always_comb begin
        fast_fpu_en_pulse = 1'b0;
        slow_fpu_en_pulse = 1'b0;
        fpu_stall         = 1'b0;
        case (state)
            FPU_IDLE: begin
                fast_fpu_en_pulse = (dispatch == DU_FAST_FPU);
                slow_fpu_en_pulse = (dispatch == DU_SLOW_FPU);
                fpu_stall = fast_fpu_en_pulse || slow_fpu_en_pulse; // issue cycle
            end
            FPU_WAIT: fpu_stall = !unit_valid; // released in the valid cycle
            default:  fpu_stall = 1'b0;
        endcase
    end

    always_comb begin
        state_nxt    = state;
        slow_sel_nxt = slow_sel;
        case (state)
            FPU_IDLE: begin
                if (fast_fpu_en_pulse || slow_fpu_en_pulse) begin
                    state_nxt    = FPU_WAIT;
                    slow_sel_nxt = slow_fpu_en_pulse;
                end
            end
            FPU_WAIT: begin
                if (unit_valid) begin
                    state_nxt = FPU_DONE;
                end
            end
            FPU_DONE: begin
                // result instr still in E until it moves on or is killed
                if (!stall_e || flush_e) begin
                    state_nxt = FPU_IDLE;
                end
            end
            default: state_nxt = FPU_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= FPU_IDLE;
            slow_sel <= 1'b0;
        end else begin
            state    <= state_nxt;
            slow_sel <= slow_sel_nxt;
        end
    end

    // only one unit may be started per instruction
    a_one_unit: assert property (@(posedge clk) disable iff (!rst_n)
        !(fast_fpu_en_pulse && slow_fpu_en_pulse))
        else $error("fpu_issue_ctrl: fast and slow start together");

    // a start is a single-cycle pulse
    a_pulse_width: assert property (@(posedge clk) disable iff (!rst_n)
        (fast_fpu_en_pulse || slow_fpu_en_pulse)
        |=> !(fast_fpu_en_pulse || slow_fpu_en_pulse))
        else $error("fpu_issue_ctrl: start pulse in two cycles in a row");

endmodule

//--- hw/load_use_detect.sv
`timescale 1ns/1ps

module load_use_detect import hazard_pkg::*; (
    input  stage_d_t stg_d,
    input  stage_e_t stg_e,
    output logic     lw_stall
);

    logic late_result; // value only known after the memory stage
    logic int_hit;
    logic fp_hit;

    // fmv.w.x is forwarded from M, no stall for it
    assign late_result = (stg_e.result_src == RES_MEM) || (stg_e.result_src == RES_IN);

    always_comb begin
        int_hit = 1'b0;
        if (stg_e.reg_write && stg_e.rd != 5'd0) begin
            if (is_int_rs1(stg_d.s_fpu, stg_d.mem_write) && stg_d.rs1 == stg_e.rd) begin
                int_hit = 1'b1;
            end
            if (is_int_rs2(stg_d.s_fpu) && stg_d.rs2 == stg_e.rd) begin
                int_hit = 1'b1;
            end
        end
    end

    always_comb begin
        fp_hit = 1'b0;
        if (stg_e.fpu_reg_write) begin
            if (is_fp_rs1(stg_d.s_fpu, stg_d.mem_write) && stg_d.rs1 == stg_e.rd) begin
                fp_hit = 1'b1;
            end
            if (is_fp_rs23(stg_d.s_fpu)
                && (stg_d.rs2 == stg_e.rd || stg_d.rs3 == stg_e.rd)) begin
                fp_hit = 1'b1; // flw then fmadd etc
            end
        end
    end

    assign lw_stall = late_result && (int_hit || fp_hit);

endmodule

//--- hw/fpu_forward.sv
`timescale 1ns/1ps

module fpu_forward import hazard_pkg::*; (
    input  stage_e_t   stg_e,
    input  stage_m_t   stg_m,
    input  stage_w_t   stg_w,
    output logic [1:0] frd1_sel,
    output logic [1:0] frd2_sel,
    output logic [1:0] frd3_sel
);

    // f0 is a real register, so no zero check
    function automatic logic [1:0] pick(
        input logic [4:0] rs,
        input logic       is_fp,
        input stage_m_t   m,
        input stage_w_t   w
    );
        logic [1:0] code;
        code = FFWD_NONE;
        if (is_fp) begin
            if (m.fpu_reg_write && m.rd == rs) begin
                case (m.result_src)
                    RES_INT_TO_FPU: code = FFWD_RD1_M;     // fmv.w.x ahead
                    RES_FPU:        code = FFWD_FPU_RES_M;
                    default:        code = FFWD_NONE;
                endcase
            end else if (w.fpu_reg_write && w.rd == rs) begin
                code = FFWD_WB;
            end
        end
        return code;
    endfunction

    logic rs1_fp;
    logic rs23_fp;

    assign rs1_fp  = is_fp_rs1(stg_e.s_fpu, stg_e.mem_write); // fsw rs1 is integer
    assign rs23_fp = is_fp_rs23(stg_e.s_fpu);

    always_comb begin
        frd1_sel = pick(stg_e.rs1, rs1_fp, stg_m, stg_w);
        frd2_sel = pick(stg_e.rs2, rs23_fp, stg_m, stg_w);
        frd3_sel = pick(stg_e.rs3, rs23_fp, stg_m, stg_w);
    end

endmodule

//--- hw/int_forward.sv
`timescale 1ns/1ps

module int_forward import hazard_pkg::*; (
    input  stage_e_t   stg_e,
    input  stage_m_t   stg_m,
    input  stage_w_t   stg_w,
    output logic [2:0] rd1_sel,
    output logic [2:0] rd2_sel
);

    // memory-stage result kind to mux select
    function automatic logic [2:0] mem_code(input logic [2:0] src);
        logic [2:0] code;
        case (src)
            RES_ALU:     code = FWD_ALU_M;
            RES_PC4:     code = FWD_PC4_M;
            RES_IMM:     code = FWD_IMM_M;
            RES_FPU_RD1: code = FWD_FPU_RD1_M;
            RES_FPU:     code = FWD_FPU_RES_M;
            default:     code = FWD_ALU_M; // lw, in, fmv.w.x are no sources here
        endcase
        return code;
    endfunction

    function automatic logic [2:0] pick(
        input logic [4:0] rs,
        input logic       is_int,
        input stage_m_t   m,
        input stage_w_t   w
    );
        logic [2:0] code;
        code = FWD_NONE;
        if (is_int && rs != 5'd0) begin // x0 is never forwarded
            if (m.reg_write && m.rd == rs) begin
                code = mem_code(m.result_src); // newest value wins
            end else if (w.reg_write && w.rd == rs) begin
                code = FWD_WB;
            end
        end
        return code;
    endfunction

    logic rs1_int;
    logic rs2_int;

    assign rs1_int = is_int_rs1(stg_e.s_fpu, stg_e.mem_write);
    assign rs2_int = is_int_rs2(stg_e.s_fpu);

    always_comb begin
        rd1_sel = pick(stg_e.rs1, rs1_int, stg_m, stg_w);
        rd2_sel = pick(stg_e.rs2, rs2_int, stg_m, stg_w);
    end

    // the operand mux has no input behind 011
    always_comb begin
        assert final (rd1_sel != FWD_RSVD && rd2_sel != FWD_RSVD)
            else $error("int_forward: reserved select 011 on rd1 or rd2");
    end

endmodule

//--- hw/hazard_pkg.sv
package hazard_pkg;

    // what a stage writes back
    localparam logic [2:0] RES_ALU        = 3'b000;
    localparam logic [2:0] RES_MEM        = 3'b001; // load
    localparam logic [2:0] RES_PC4        = 3'b010;
    localparam logic [2:0] RES_INT_TO_FPU = 3'b011; // fmv.w.x
    localparam logic [2:0] RES_IMM        = 3'b100;
    localparam logic [2:0] RES_FPU_RD1    = 3'b101;
    localparam logic [2:0] RES_FPU        = 3'b110;
    localparam logic [2:0] RES_IN         = 3'b111; // input port

    // unit that runs the execute-stage instruction
    localparam logic [3:0] DU_INT      = 4'd0;
    localparam logic [3:0] DU_FAST_FPU = 4'd1;
    localparam logic [3:0] DU_SLOW_FPU = 4'd2;
    localparam logic [3:0] DU_MEM      = 4'd3;

    // integer operand mux select
    localparam logic [2:0] FWD_ALU_M     = 3'b000;
    localparam logic [2:0] FWD_WB        = 3'b001;
    localparam logic [2:0] FWD_PC4_M     = 3'b010;
    localparam logic [2:0] FWD_RSVD      = 3'b011; // never driven
    localparam logic [2:0] FWD_IMM_M     = 3'b100;
    localparam logic [2:0] FWD_FPU_RD1_M = 3'b101;
    localparam logic [2:0] FWD_FPU_RES_M = 3'b110;
    localparam logic [2:0] FWD_NONE      = 3'b111;

    // fp operand mux select
    localparam logic [1:0] FFWD_NONE      = 2'b00;
    localparam logic [1:0] FFWD_WB        = 2'b01;
    localparam logic [1:0] FFWD_FPU_RES_M = 2'b10;
    localparam logic [1:0] FFWD_RD1_M     = 2'b11;

    // fpu issue fsm
    localparam logic [1:0] FPU_IDLE = 2'd0;
    localparam logic [1:0] FPU_WAIT = 2'd1;
    localparam logic [1:0] FPU_DONE = 2'd2;

    typedef struct packed {
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rs3;
        logic       s_fpu;
        logic       mem_write;
    } stage_d_t;

    typedef struct packed {
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rs3;
        logic [4:0] rd;
        logic       pc_src;
        logic [2:0] result_src;
        logic       mem_write;
        logic       s_fpu;
        logic       reg_write;
        logic       fpu_reg_write;
        logic [3:0] dispatch;
    } stage_e_t;

    typedef struct packed {
        logic [4:0] rd;
        logic [2:0] result_src;
        logic       reg_write;
        logic       fpu_reg_write;
        logic       mem_read;
        logic       mem_write;
    } stage_m_t;

    typedef struct packed {
        logic [4:0] rd;
        logic       reg_write;
        logic       fpu_reg_write;
    } stage_w_t;

    typedef struct packed {
        logic stall_f;
        logic stall_d;
        logic flush_d;
        logic stall_e;
        logic flush_e;
        logic stall_m;
        logic flush_m;
        logic stall_w;
    } pipe_ctrl_t;

    typedef struct packed {
        logic [2:0] rd1;
        logic [2:0] rd2;
        logic [1:0] fpu_rd1;
        logic [1:0] fpu_rd2;
        logic [1:0] fpu_rd3;
    } fwd_sel_t;

    // operand classes; fsw still takes its address from integer rs1
    function automatic logic is_int_rs1(input logic s_fpu, input logic mem_write);
        return !s_fpu || mem_write;
    endfunction

    function automatic logic is_int_rs2(input logic s_fpu);
        return !s_fpu;
    endfunction

    function automatic logic is_fp_rs1(input logic s_fpu, input logic mem_write);
        return s_fpu && !mem_write;
    endfunction

    function automatic logic is_fp_rs23(input logic s_fpu);
        return s_fpu;
    endfunction

endpackage
